/* rtl/dcache_pkg.sv */
package dcache_pkg;

    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int BYTES_PER_WORD = WORD_W / 8;
    localparam int WAY_NUM        = 2;
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int SETS           = 128;

    // address field positions
    localparam int TAG_LSB        = 12;
    localparam int INDEX_LSB      = 5;
    localparam int WORD_LSB       = 2;

    localparam int TAG_W          = ADDR_W - TAG_LSB;
    localparam int INDEX_W        = TAG_LSB - INDEX_LSB;
    localparam int WORD_SEL_W     = INDEX_LSB - WORD_LSB;

    typedef logic [ADDR_W-1:0]         addr_t;
    typedef logic [WORD_W-1:0]         word_t;
    typedef logic [BYTES_PER_WORD-1:0] byte_en_t;
    typedef logic [LINE_W-1:0]         line_t;     // word 0 in low bits
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [WORD_SEL_W-1:0]     word_sel_t;
    typedef logic [WAY_NUM-1:0]        way_vec_t;

    typedef enum logic [2:0] {
        op_none,
        op_load,
        op_store,
        op_refill,
        op_invalidate
    } cache_op_t;

endpackage

/* rtl/dcache_way.sv */
module dcache_way (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  dcache_pkg::index_t                                   index,
    input  logic                                                 tag_we,
    input  dcache_pkg::tag_t                                     wtag,
    input  logic                                                 valid_we,
    input  logic                                                 wvalid,
    input  logic                                                 dirty_we,
    input  logic                                                 wdirty,
    input  dcache_pkg::byte_en_t [dcache_pkg::WORDS_PER_LINE-1:0] word_we,
    input  dcache_pkg::line_t                                    wline,
    output dcache_pkg::tag_t                                     rtag,
    output logic                                                 rvalid,
    output logic                                                 rdirty,
    output dcache_pkg::line_t                                    rline
);
    import dcache_pkg::*;

    tag_t            tag_mem [SETS];
    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[index] <= wtag;
        end
        rtag <= tag_mem[index];   // read-first
    end

    // one data bank per word of the line
    for (genvar w = 0; w < WORDS_PER_LINE; w++) begin : g_word
        word_t mem [SETS];
        word_t rword;

        always_ff @(posedge clk) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (word_we[w][b]) begin
                    mem[index][8*b +: 8] <= wline[WORD_W*w + 8*b +: 8];
                end
            end
            rword <= mem[index];
        end

        assign rline[WORD_W*w +: WORD_W] = rword;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
            rvalid  <= 1'b0;
            rdirty  <= 1'b0;
        end else begin
            if (valid_we) begin
                valid_q[index] <= wvalid;
            end
            if (dirty_we) begin
                dirty_q[index] <= wdirty;
            end
            rvalid <= valid_q[index];
            rdirty <= dirty_q[index];
        end
    end

endmodule

/* rtl/dcache_write_ctrl.sv */
module dcache_write_ctrl (
    input  dcache_pkg::cache_op_t                                op,
    input  dcache_pkg::addr_t                                    ad,
    input  dcache_pkg::way_vec_t                                 way_hit,
    input  logic                                                 refill_way,
    input  dcache_pkg::byte_en_t                                 byte_en,
    input  dcache_pkg::word_t                                    store_data,
    input  dcache_pkg::line_t                                    refill_line,
    output dcache_pkg::way_vec_t                                 tag_we,
    output dcache_pkg::way_vec_t                                 valid_we,
    output dcache_pkg::way_vec_t                                 dirty_we,
    output logic                                                 wvalid,
    output logic                                                 wdirty,
    output dcache_pkg::byte_en_t [dcache_pkg::WORDS_PER_LINE-1:0] word_we0,
    output dcache_pkg::byte_en_t [dcache_pkg::WORDS_PER_LINE-1:0] word_we1,
    output dcache_pkg::line_t                                    wline
);
    import dcache_pkg::*;

    way_vec_t                      refill_sel;
    way_vec_t                      inval_sel;
    word_sel_t                     word_sel;
    byte_en_t [WORDS_PER_LINE-1:0] store_word_we;
    byte_en_t [WORDS_PER_LINE-1:0] word_we [WAY_NUM];

    assign refill_sel = refill_way ? 2'b10 : 2'b01;  // one-hot
    assign inval_sel  = ad[0] ? 2'b10 : 2'b01;       // way named by ad bit 0
    assign word_sel   = ad[WORD_LSB +: WORD_SEL_W];

    always_comb begin
        store_word_we           = '0;
        store_word_we[word_sel] = byte_en;
    end

    always_comb begin
        tag_we   = '0;
        valid_we = '0;
        dirty_we = '0;
        wvalid   = 1'b0;
        wdirty   = 1'b0;
        for (int w = 0; w < WAY_NUM; w++) begin
            word_we[w] = '0;
        end

        case (op)
            op_refill: begin
                tag_we   = refill_sel;
                valid_we = refill_sel;
                dirty_we = refill_sel;   // clean line
                wvalid   = 1'b1;
                for (int w = 0; w < WAY_NUM; w++) begin
                    if (refill_sel[w]) begin
                        word_we[w] = '1;
                    end
                end
            end
            op_store: begin
                // a miss leaves way_hit at zero, so nothing is written
                dirty_we = way_hit;
                wdirty   = 1'b1;
                for (int w = 0; w < WAY_NUM; w++) begin
                    if (way_hit[w]) begin
                        word_we[w] = store_word_we;
                    end
                end
            end
            op_invalidate: begin
                valid_we = inval_sel;
            end
            default: begin
            end
        endcase
    end

    assign wline    = (op == op_refill) ? refill_line : {WORDS_PER_LINE{store_data}};
    assign word_we0 = word_we[0];
    assign word_we1 = word_we[1];

endmodule

/* rtl/dcache_hit_select.sv */
module dcache_hit_select (
    input  dcache_pkg::addr_t    pa,
    input  dcache_pkg::tag_t     rtag0,
    input  dcache_pkg::tag_t     rtag1,
    input  logic                 rvalid0,
    input  logic                 rvalid1,
    input  logic                 rdirty0,
    input  logic                 rdirty1,
    input  dcache_pkg::line_t    rline0,
    input  dcache_pkg::line_t    rline1,
    output dcache_pkg::way_vec_t way_hit,
    output logic                 hit,
    output dcache_pkg::word_t    load_data,
    output logic                 dirty,
    output dcache_pkg::line_t    dirty_data
);
    import dcache_pkg::*;

    tag_t      pa_tag;
    word_sel_t word_sel;
    line_t     sel_line;

    assign pa_tag   = pa[TAG_LSB +: TAG_W];
    assign word_sel = pa[WORD_LSB +: WORD_SEL_W];

    assign way_hit[0] = rvalid0 && (rtag0 == pa_tag);
    assign way_hit[1] = rvalid1 && (rtag1 == pa_tag);
    assign hit        = |way_hit;

    // way 0 unless way 1 hits
    assign sel_line   = way_hit[1] ? rline1 : rline0;
    assign dirty      = way_hit[1] ? rdirty1 : rdirty0;
    assign dirty_data = sel_line;
    assign load_data  = sel_line[WORD_W*word_sel +: WORD_W];

endmodule

/* rtl/dcache_lru.sv */
module dcache_lru (
    input  logic               clk,
    input  logic               reset,
    input  dcache_pkg::index_t rindex,
    input  dcache_pkg::index_t windex,
    input  logic               we,
    input  logic               wdata,
    output logic               rdata
);
    import dcache_pkg::*;

    logic [SETS-1:0] lru_q;   // 1 means way 1 was used last

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
            rdata <= 1'b0;
        end else begin
            if (we) begin
                lru_q[windex] <= wdata;
            end
            rdata <= lru_q[rindex];
        end
    end

endmodule

/* rtl/dcache.sv */
module dcache (
    input  logic                  clk,
    input  logic                  reset,
    input  dcache_pkg::cache_op_t op,
    input  dcache_pkg::addr_t     ad,
    input  dcache_pkg::addr_t     pa,
    input  dcache_pkg::word_t     store_data,
    input  dcache_pkg::byte_en_t  byte_en,
    input  dcache_pkg::line_t     refill_line,
    input  logic                  refill_way,
    input  logic                  lru_update,
    output logic                  hit,
    output dcache_pkg::word_t     load_data,
    output logic                  dirty,
    output dcache_pkg::line_t     dirty_data,
    output logic                  lru
);
    import dcache_pkg::*;

    index_t   ad_index;
    index_t   pa_index;
    tag_t     ad_tag;
    way_vec_t way_hit;

    way_vec_t tag_we;
    way_vec_t valid_we;
    way_vec_t dirty_we;
    logic     wvalid;
    logic     wdirty;
    line_t    wline;
    byte_en_t [WORDS_PER_LINE-1:0] word_we0;
    byte_en_t [WORDS_PER_LINE-1:0] word_we1;

    tag_t     rtag0;
    tag_t     rtag1;
    logic     rvalid0;
    logic     rvalid1;
    logic     rdirty0;
    logic     rdirty1;
    line_t    rline0;
    line_t    rline1;

    assign ad_index = ad[INDEX_LSB +: INDEX_W];
    assign pa_index = pa[INDEX_LSB +: INDEX_W];
    assign ad_tag   = ad[TAG_LSB +: TAG_W];   // refill tag

    dcache_way u_way0 (
        .clk(clk), .reset(reset), .index(ad_index),
        .tag_we(tag_we[0]), .wtag(ad_tag),
        .valid_we(valid_we[0]), .wvalid(wvalid),
        .dirty_we(dirty_we[0]), .wdirty(wdirty),
        .word_we(word_we0), .wline(wline),
        .rtag(rtag0), .rvalid(rvalid0), .rdirty(rdirty0), .rline(rline0)
    );

    dcache_way u_way1 (
        .clk(clk), .reset(reset), .index(ad_index),
        .tag_we(tag_we[1]), .wtag(ad_tag),
        .valid_we(valid_we[1]), .wvalid(wvalid),
        .dirty_we(dirty_we[1]), .wdirty(wdirty),
        .word_we(word_we1), .wline(wline),
        .rtag(rtag1), .rvalid(rvalid1), .rdirty(rdirty1), .rline(rline1)
    );

    dcache_write_ctrl u_write_ctrl (
        .op(op), .ad(ad), .way_hit(way_hit), .refill_way(refill_way),
        .byte_en(byte_en), .store_data(store_data), .refill_line(refill_line),
        .tag_we(tag_we), .valid_we(valid_we), .dirty_we(dirty_we),
        .wvalid(wvalid), .wdirty(wdirty),
        .word_we0(word_we0), .word_we1(word_we1), .wline(wline)
    );

    dcache_hit_select u_hit_select (
        .pa(pa),
        .rtag0(rtag0), .rtag1(rtag1),
        .rvalid0(rvalid0), .rvalid1(rvalid1),
        .rdirty0(rdirty0), .rdirty1(rdirty1),
        .rline0(rline0), .rline1(rline1),
        .way_hit(way_hit), .hit(hit), .load_data(load_data),
        .dirty(dirty), .dirty_data(dirty_data)
    );

    // read by ad index, written by pa index
    dcache_lru u_lru (
        .clk(clk), .reset(reset),
        .rindex(ad_index), .windex(pa_index),
        .we(lru_update), .wdata(way_hit[1]),
        .rdata(lru)
    );

endmodule

/* sim/dcache_tb.sv */
module dcache_tb;
    import dcache_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES   = 2000;   // about ten times the test length

    localparam index_t SET_A    = 7'h15;
    localparam index_t SET_B    = 7'h2a;
    localparam tag_t   TAG_A0   = 20'h1a2b3;
    localparam tag_t   TAG_A1   = 20'h4c5d6;
    localparam tag_t   TAG_B0   = 20'h0badc;
    localparam tag_t   TAG_B1   = 20'h0cafe;
    localparam tag_t   TAG_MISS = 20'h77777;

    logic      clk;
    logic      reset;
    cache_op_t op;
    addr_t     ad;
    addr_t     pa;
    word_t     store_data;
    byte_en_t  byte_en;
    line_t     refill_line;
    logic      refill_way;
    logic      lru_update;
    logic      hit;
    word_t     load_data;
    logic      dirty;
    line_t     dirty_data;
    logic      lru;

    // expected contents per way and set
    line_t exp_line  [WAY_NUM][SETS];
    tag_t  exp_tag   [WAY_NUM][SETS];
    logic  exp_valid [WAY_NUM][SETS];
    logic  exp_dirty [WAY_NUM][SETS];
    logic  exp_lru   [SETS];

    logic [31:0] rand_state;
    int          errors;
    int          checks;
    int          cycle_count;

    dcache i_dut (
        .clk(clk), .reset(reset), .op(op), .ad(ad), .pa(pa),
        .store_data(store_data), .byte_en(byte_en),
        .refill_line(refill_line), .refill_way(refill_way),
        .lru_update(lru_update),
        .hit(hit), .load_data(load_data), .dirty(dirty),
        .dirty_data(dirty_data), .lru(lru)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic word_t random_word();
        rand_state = xorshift32(rand_state);
        return rand_state;
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[WORD_W*w +: WORD_W] = random_word();
        end
        return l;
    endfunction

    function automatic addr_t make_addr(input tag_t t, input index_t i, input word_sel_t w);
        return {t, i, w, 2'b00};
    endfunction

    function automatic word_t line_word(input line_t l, input word_sel_t w);
        return l[WORD_W*w +: WORD_W];
    endfunction

    // one bit per way whose model tag matches
    function automatic way_vec_t model_match(input addr_t a);
        index_t   idx;
        tag_t     t;
        way_vec_t m;
        idx  = a[INDEX_LSB +: INDEX_W];
        t    = a[TAG_LSB +: TAG_W];
        m[0] = exp_valid[0][idx] && (exp_tag[0][idx] == t);
        m[1] = exp_valid[1][idx] && (exp_tag[1][idx] == t);
        return m;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data,
                                          input byte_en_t be);
        word_t r;
        r = old;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (be[b]) begin
                r[8*b +: 8] = data[8*b +: 8];
            end
        end
        return r;
    endfunction

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_line(input line_t got, input line_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic drive(input cache_op_t o, input addr_t a, input addr_t p, input logic upd);
        op         = o;
        ad         = a;
        pa         = p;
        lru_update = upd;
    endtask

    // index in one cycle, compare in the next
    task automatic lookup(input addr_t a, input logic upd);
        index_t    idx;
        word_sel_t ws;
        way_vec_t  m;
        idx = a[INDEX_LSB +: INDEX_W];
        ws  = a[WORD_LSB +: WORD_SEL_W];
        next_cycle();
        drive(op_load, a, a, 1'b0);
        next_cycle();
        drive(op_none, a, a, upd);
        @(negedge clk);
        m = model_match(a);
        check_bit(hit, |m, $sformatf("hit at %h", a));
        check_bit(lru, exp_lru[idx], $sformatf("lru at %h", a));
        if (|m) begin
            check_word(load_data, line_word(exp_line[m[1]][idx], ws),
                       $sformatf("load_data at %h", a));
            check_bit(dirty, exp_dirty[m[1]][idx], $sformatf("dirty at %h", a));
            check_line(dirty_data, exp_line[m[1]][idx], $sformatf("dirty_data at %h", a));
        end
        if (upd) begin
            exp_lru[idx] = m[1];
        end
    endtask

    task automatic refill(input tag_t t, input index_t idx, input logic way);
        line_t l;
        l = random_line();
        next_cycle();
        drive(op_refill, make_addr(t, idx, '0), '0, 1'b0);
        refill_line           = l;
        refill_way            = way;
        exp_line[way][idx]  = l;
        exp_tag[way][idx]   = t;
        exp_valid[way][idx] = 1'b1;
        exp_dirty[way][idx] = 1'b0;
    endtask

    task automatic store(input addr_t a, input word_t data, input byte_en_t be);
        index_t    idx;
        word_sel_t ws;
        way_vec_t  m;
        line_t     l;
        idx = a[INDEX_LSB +: INDEX_W];
        ws  = a[WORD_LSB +: WORD_SEL_W];
        next_cycle();
        drive(op_load, a, a, 1'b0);
        next_cycle();
        drive(op_store, a, a, 1'b0);   // ad still holds the index
        store_data = data;
        byte_en    = be;
        @(negedge clk);
        m = model_match(a);
        check_bit(hit, |m, $sformatf("store hit at %h", a));
        if (|m) begin
            l = exp_line[m[1]][idx];
            l[WORD_W*ws +: WORD_W] = merge_bytes(line_word(l, ws), data, be);
            exp_line[m[1]][idx]  = l;
            exp_dirty[m[1]][idx] = 1'b1;
        end
    endtask

    task automatic invalidate(input index_t idx, input logic way);
        next_cycle();
        drive(op_invalidate, make_addr('0, idx, '0) | addr_t'(way), '0, 1'b0);   // ad[0] picks way
        exp_valid[way][idx] = 1'b0;
    endtask

    task automatic reload_line(input tag_t t, input index_t idx);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            lookup(make_addr(t, idx, word_sel_t'(w)), 1'b0);
        end
    endtask

    task automatic reset_miss();
        addr_t a;
        for (int n = 0; n < 4; n++) begin
            a = random_word();
            lookup(a, 1'b0);
            check_bit(hit, 1'b0, "hit after reset");
            check_bit(lru, 1'b0, "lru after reset");
        end
    endtask

    task automatic refill_then_load();
        refill(TAG_A0, SET_A, 1'b0);
        refill(TAG_A1, SET_A, 1'b1);
        reload_line(TAG_A0, SET_A);
        reload_line(TAG_A1, SET_A);
    endtask

    task automatic store_byte_enables();
        store(make_addr(TAG_A0, SET_A, 3'd2), random_word(), 4'b0101);
        store(make_addr(TAG_A0, SET_A, 3'd5), random_word(), 4'b1000);
        store(make_addr(TAG_A1, SET_A, 3'd0), random_word(), 4'b1111);
        store(make_addr(TAG_A1, SET_A, 3'd7), random_word(), 4'b0110);
        reload_line(TAG_A0, SET_A);
        reload_line(TAG_A1, SET_A);
        // a miss must leave both lines alone
        store(make_addr(TAG_MISS, SET_A, 3'd2), random_word(), 4'b1111);
        reload_line(TAG_A0, SET_A);
        reload_line(TAG_A1, SET_A);
        // refill over a dirty line leaves it clean
        refill(TAG_A0, SET_A, 1'b0);
        reload_line(TAG_A0, SET_A);
    endtask

    task automatic invalidate_one_way();
        refill(TAG_B0, SET_B, 1'b0);
        refill(TAG_B1, SET_B, 1'b1);
        lookup(make_addr(TAG_B0, SET_B, 3'd3), 1'b0);
        lookup(make_addr(TAG_B1, SET_B, 3'd3), 1'b0);
        invalidate(SET_B, 1'b0);
        lookup(make_addr(TAG_B0, SET_B, 3'd3), 1'b0);
        check_bit(hit, 1'b0, "invalidated way");
        lookup(make_addr(TAG_B1, SET_B, 3'd6), 1'b0);
        check_bit(hit, 1'b1, "other way after invalidate");
        invalidate(SET_B, 1'b1);
        lookup(make_addr(TAG_B1, SET_B, 3'd6), 1'b0);
        check_bit(hit, 1'b0, "invalidated way 1");
    endtask

    task automatic lru_tracking();
        lookup(make_addr(TAG_A1, SET_A, 3'd1), 1'b1);
        lookup(make_addr(TAG_A1, SET_A, 3'd1), 1'b0);
        check_bit(lru, 1'b1, "lru after way 1 hit");
        lookup(make_addr(TAG_A0, SET_A, 3'd4), 1'b1);
        lookup(make_addr(TAG_A0, SET_A, 3'd4), 1'b0);
        check_bit(lru, 1'b0, "lru after way 0 hit");
        lookup(make_addr(TAG_B1, SET_B, 3'd0), 1'b0);   // other set untouched
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        op          = op_none;
        ad          = '0;
        pa          = '0;
        store_data  = '0;
        byte_en     = '0;
        refill_line = '0;
        refill_way  = 1'b0;
        lru_update  = 1'b0;
        rand_state  = 32'hffb1;
        errors      = 0;
        checks      = 0;
        for (int s = 0; s < SETS; s++) begin
            exp_lru[s] = 1'b0;
            for (int w = 0; w < WAY_NUM; w++) begin
                exp_line[w][s]  = '0;
                exp_tag[w][s]   = '0;
                exp_valid[w][s] = 1'b0;
                exp_dirty[w][s] = 1'b0;
            end
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        reset_miss();
        refill_then_load();
        store_byte_enables();
        invalidate_one_way();
        lru_tracking();

        next_cycle();
        drive(op_none, '0, '0, 1'b0);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* dcache.f */
rtl/dcache_pkg.sv
rtl/dcache_way.sv
rtl/dcache_write_ctrl.sv
rtl/dcache_hit_select.sv
rtl/dcache_lru.sv
rtl/dcache.sv
sim/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module dcache_tb -f dcache.f -o dcache_sim \
    && ./obj_dir/dcache_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"
